// File: hw/as_proto_pkg.sv
// Byte codes of the host stream protocol.
package as_proto_pkg;

  // Command bytes sent by the host.
  localparam logic [7:0] CMD_NOP   = 8'd0;   // No response.
  localparam logic [7:0] CMD_READ  = 8'd1;   // Followed by address low, address high.
  localparam logic [7:0] CMD_WRITE = 8'd2;   // Address low/high, then data low/high.
  localparam logic [7:0] CMD_PING  = 8'd8;

  // Response bytes returned to the host.
  // A read that succeeds adds data low and data high after RESP_ACK.
  localparam logic [7:0] RESP_ACK      = 8'd1;
  localparam logic [7:0] RESP_PING     = 8'd8;
  localparam logic [7:0] RESP_CMDERROR = 8'd253;  // Unknown command byte.
  localparam logic [7:0] RESP_BUSERROR = 8'd254;  // Bus cycle ended in err.

endpackage

// File: hw/wb_map_pkg.sv
// Wishbone address map of the register subsystem.
package wb_map_pkg;

  localparam int NUM_BANKS     = 4;
  localparam int REGS_PER_BANK = 16;   // Registers in each bank.

  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 16;
  localparam int BANK_W   = 4;         // Upper address nibble.
  localparam int OFFSET_W = 12;        // Register offset inside a bank.

  // Split view of an address word.
  typedef struct packed {
    logic [BANK_W-1:0]   bank;
    logic [OFFSET_W-1:0] offset;
  } wb_addr_split_t;

  // One address word, seen either raw or as bank and offset.
  // The bridge fills the flat view byte by byte, the banks decode the split view.
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    wb_addr_split_t    split;
  } wb_addr_u;

endpackage

// File: hw/as_wb_bridge.sv
`timescale 1ns/1ps

module as_wb_bridge (
  input  logic                            clk,
  input  logic                            reset,
  // Command stream from the host.
  input  logic [7:0]                      as_data_i,
  input  logic                            as_dstrb_i,
  output logic                            as_busy_o,
  // Response stream to the host.
  output logic [7:0]                      as_data_o,
  output logic                            as_dstrb_o,
  input  logic                            as_busy_i,
  // Wishbone master.
  output logic                            wb_cyc_o,
  output logic                            wb_stb_o,
  output logic                            wb_we_o,
  output wb_map_pkg::wb_addr_u            wb_adr_o,
  output logic [wb_map_pkg::DATA_W-1:0]   wb_dat_o,
  input  logic [wb_map_pkg::DATA_W-1:0]   wb_dat_i,
  input  logic                            wb_ack_i,
  input  logic                            wb_err_i
);
  import as_proto_pkg::*;
  import wb_map_pkg::*;

  localparam logic [1:0] ST_COMMAND  = 2'd0;
  localparam logic [1:0] ST_COLLECT  = 2'd1;
  localparam logic [1:0] ST_WAIT     = 2'd2;
  localparam logic [1:0] ST_RESPONSE = 2'd3;

  logic [1:0]        state;
  logic [1:0]        collect_cnt;
  logic              bus_strb;
  logic [7:0]        cmd_type;
  wb_addr_u          cmd_addr;
  logic [DATA_W-1:0] cmd_data;

  logic [7:0]        resp_code;
  logic [DATA_W-1:0] resp_data;
  logic              resp_long;    // Read ack carries two data bytes.

  logic              ser_active;
  logic [1:0]        ser_idx;
  logic [7:0]        ser_code;
  logic [DATA_W-1:0] ser_data;
  logic              ser_long;

  logic              byte_in;
  logic              byte_out;

  // Host may only send while parsing and nothing is in flight.
  assign as_busy_o = (state == ST_WAIT) || (state == ST_RESPONSE) || ser_active;
  assign byte_in   = as_dstrb_i && !as_busy_o;
  assign byte_out  = ser_active && !as_busy_i;

  always_ff @(posedge clk) begin
    bus_strb <= 1'b0;  // One-cycle strobe.
    if (reset) begin
      state       <= ST_COMMAND;
      collect_cnt <= 2'd0;
    end else begin
      case (state)
        ST_COMMAND: begin
          collect_cnt <= 2'd0;
          if (byte_in) begin
            cmd_type <= as_data_i;
            case (as_data_i)
              CMD_NOP: begin
              end
              CMD_READ, CMD_WRITE: begin
                state <= ST_COLLECT;
              end
              CMD_PING: begin
                resp_code <= RESP_PING;
                resp_long <= 1'b0;
                state     <= ST_RESPONSE;
              end
              default: begin
                resp_code <= RESP_CMDERROR;
                resp_long <= 1'b0;
                state     <= ST_RESPONSE;
              end
            endcase
          end
        end

        ST_COLLECT: begin
          if (byte_in) begin
            collect_cnt <= collect_cnt + 2'd1;
            case (collect_cnt)
              2'd0: cmd_addr.flat[7:0] <= as_data_i;
              2'd1: begin
                cmd_addr.flat[15:8] <= as_data_i;
                if (cmd_type == CMD_READ) begin
                  bus_strb <= 1'b1;
                  state    <= ST_WAIT;
                end
              end
              2'd2: cmd_data[7:0] <= as_data_i;
              default: begin
                cmd_data[15:8] <= as_data_i;
                bus_strb       <= 1'b1;
                state          <= ST_WAIT;
              end
            endcase
          end
        end

        ST_WAIT: begin
          // Error wins if both arrive together.
          if (wb_err_i) begin
            resp_code <= RESP_BUSERROR;
            resp_long <= 1'b0;
            state     <= ST_RESPONSE;
          end else if (wb_ack_i) begin
            resp_code <= RESP_ACK;
            resp_data <= wb_dat_i;
            resp_long <= (cmd_type == CMD_READ);
            state     <= ST_RESPONSE;
          end
        end

        default: begin
          if (!ser_active) begin
            state <= ST_COMMAND;  // Serializer takes the response now.
          end
        end
      endcase
    end
  end

  // Response serializer.
  always_ff @(posedge clk) begin
    if (reset) begin
      ser_active <= 1'b0;
      ser_idx    <= 2'd0;
    end else if (!ser_active) begin
      ser_idx <= 2'd0;
      if (state == ST_RESPONSE) begin
        ser_active <= 1'b1;
        ser_code   <= resp_code;
        ser_data   <= resp_data;
        ser_long   <= resp_long;
      end
    end else if (byte_out) begin
      ser_idx <= ser_idx + 2'd1;
      if (ser_idx == 2'd2 || (ser_idx == 2'd0 && !ser_long)) begin
        ser_active <= 1'b0;
      end
    end
  end

  always_comb begin
    case (ser_idx)
      2'd0:    as_data_o = ser_code;
      2'd1:    as_data_o = ser_data[7:0];    // Low byte first.
      default: as_data_o = ser_data[15:8];
    endcase
  end

  assign as_dstrb_o = ser_active;  // Held high under back-pressure.

  assign wb_cyc_o = bus_strb;
  assign wb_stb_o = bus_strb;
  assign wb_we_o  = (cmd_type == CMD_WRITE);
  assign wb_adr_o = cmd_addr;
  assign wb_dat_o = cmd_data;

endmodule

// File: hw/wb_reg_bank.sv
`timescale 1ns/1ps

module wb_reg_bank #(
  parameter int BANK_INDEX = 0
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  wb_map_pkg::wb_addr_u          wb_adr_i,
  input  logic [wb_map_pkg::DATA_W-1:0] wb_dat_i,
  output logic                          bank_ack_o,
  output logic                          bank_err_o,
  output logic [wb_map_pkg::DATA_W-1:0] bank_dat_o
);
  import wb_map_pkg::*;

  logic [DATA_W-1:0] regs [REGS_PER_BANK];
  logic [DATA_W-1:0] rd_data;
  logic              hit;
  logic              in_range;
  logic [$clog2(REGS_PER_BANK)-1:0] idx;

  assign hit      = wb_stb_i && (int'(wb_adr_i.split.bank) == BANK_INDEX);
  assign in_range = int'(wb_adr_i.split.offset) < REGS_PER_BANK;
  assign idx      = wb_adr_i.split.offset[$clog2(REGS_PER_BANK)-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      bank_ack_o <= 1'b0;
      bank_err_o <= 1'b0;
      rd_data    <= '0;
      for (int i = 0; i < REGS_PER_BANK; i++) begin
        regs[i] <= '0;
      end
    end else begin
      bank_ack_o <= hit && in_range;
      bank_err_o <= hit && !in_range;  // Offset past the last register.
      rd_data    <= '0;
      if (hit && in_range) begin
        rd_data <= regs[idx];
        if (wb_we_i) begin
          regs[idx] <= wb_dat_i;
        end
      end
    end
  end

  // Idle banks put zero on their lane so the merger can OR them.
  assign bank_dat_o = bank_ack_o ? rd_data : '0;

endmodule

// File: hw/wb_resp_merge.sv
`timescale 1ns/1ps

module wb_resp_merge (
  input  logic                                                wb_stb_i,
  input  wb_map_pkg::wb_addr_u                                wb_adr_i,
  input  logic [wb_map_pkg::NUM_BANKS-1:0]                    bank_ack_i,
  input  logic [wb_map_pkg::NUM_BANKS-1:0]                    bank_err_i,
  input  logic [wb_map_pkg::NUM_BANKS*wb_map_pkg::DATA_W-1:0] bank_dat_i,
  output logic                                                wb_ack_o,
  output logic                                                wb_err_o,
  output logic [wb_map_pkg::DATA_W-1:0]                       wb_dat_o
);
  import wb_map_pkg::*;

  logic unmapped;

  // No bank owns this range, so answer in the strobe cycle.
  assign unmapped = wb_stb_i && (int'(wb_adr_i.split.bank) >= NUM_BANKS);

  assign wb_ack_o = |bank_ack_i;
  assign wb_err_o = (|bank_err_i) || unmapped;

  always_comb begin
    wb_dat_o = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      wb_dat_o = wb_dat_o | bank_dat_i[i*DATA_W +: DATA_W];
    end
  end

endmodule

// File: hw/as_wb_top.sv
`timescale 1ns/1ps

module as_wb_top (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] as_data_i,
  input  logic       as_dstrb_i,
  output logic       as_busy_o,
  output logic [7:0] as_data_o,
  output logic       as_dstrb_o,
  input  logic       as_busy_i
);
  import wb_map_pkg::*;

  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        bus_stb;
  logic                        wb_we;
  wb_addr_u                    wb_adr;
  logic [DATA_W-1:0]           wb_dat_w;
  logic [DATA_W-1:0]           wb_dat_r;
  logic                        wb_ack;
  logic                        wb_err;

  logic [NUM_BANKS-1:0]        bank_ack;
  logic [NUM_BANKS-1:0]        bank_err;
  logic [NUM_BANKS*DATA_W-1:0] bank_dat;

  assign bus_stb = wb_cyc && wb_stb;  // Banks only see a strobe inside a cycle.

  as_wb_bridge bridge_i (
    .clk        (clk),
    .reset      (reset),
    .as_data_i  (as_data_i),
    .as_dstrb_i (as_dstrb_i),
    .as_busy_o  (as_busy_o),
    .as_data_o  (as_data_o),
    .as_dstrb_o (as_dstrb_o),
    .as_busy_i  (as_busy_i),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_w),
    .wb_dat_i   (wb_dat_r),
    .wb_ack_i   (wb_ack),
    .wb_err_i   (wb_err)
  );

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    wb_reg_bank #(
      .BANK_INDEX (g)
    ) bank_i (
      .clk        (clk),
      .reset      (reset),
      .wb_stb_i   (bus_stb),
      .wb_we_i    (wb_we),
      .wb_adr_i   (wb_adr),
      .wb_dat_i   (wb_dat_w),
      .bank_ack_o (bank_ack[g]),
      .bank_err_o (bank_err[g]),
      .bank_dat_o (bank_dat[g*DATA_W +: DATA_W])
    );
  end

  wb_resp_merge merge_i (
    .wb_stb_i   (bus_stb),
    .wb_adr_i   (wb_adr),
    .bank_ack_i (bank_ack),
    .bank_err_i (bank_err),
    .bank_dat_i (bank_dat),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_dat_o   (wb_dat_r)
  );

endmodule

// File: tb/as_wb_tb.sv
`timescale 1ns/1ps

module as_wb_tb;
  import as_proto_pkg::*;
  import wb_map_pkg::*;

  localparam int CYCLES_PER_TEST = 200;  // Generous bound with random back-pressure.
  localparam int NOP_WAIT        = 8;

  logic       clk = 1'b0;
  logic       reset;
  logic [7:0] as_data_i;
  logic       as_dstrb_i;
  logic       as_busy_o;
  logic [7:0] as_data_o;
  logic       as_dstrb_o;
  logic       as_busy_i = 1'b0;

  // Test table. Command bytes are packed with the first byte in bits 7:0.
  string       t_name  [$];
  int          t_ncmd  [$];
  logic [39:0] t_cmd   [$];
  logic [7:0]  t_code  [$];
  int          t_nresp [$];

  logic [DATA_W-1:0] ref_regs [NUM_BANKS*REGS_PER_BANK];
  logic [7:0]        rx_q [$];
  logic              hold_pending = 1'b0;
  logic [7:0]        hold_data;
  int                hold_errors = 0;
  int                err_count;
  int                check_count;
  int                pass_count;
  int                num_tests = 0;
  int unsigned       seed_val;

  as_wb_top as_wb_top_i (
    .clk        (clk),
    .reset      (reset),
    .as_data_i  (as_data_i),
    .as_dstrb_i (as_dstrb_i),
    .as_busy_o  (as_busy_o),
    .as_data_o  (as_data_o),
    .as_dstrb_o (as_dstrb_o),
    .as_busy_i  (as_busy_i)
  );

  always #5 clk = ~clk;

  // Host side of the response stream with random back-pressure.
  always @(negedge clk) begin
    if (reset) begin
      as_busy_i    = 1'b0;
      hold_pending = 1'b0;
    end else begin
      if (hold_pending && (as_dstrb_o !== 1'b1 || as_data_o !== hold_data)) begin
        $display("Response byte changed or was dropped while the host was busy");
        hold_errors++;
      end
      as_busy_i    = ($urandom % 3) == 0;
      hold_pending = 1'b0;
      if (as_dstrb_o === 1'b1) begin
        if (as_busy_i) begin
          hold_pending = 1'b1;
          hold_data    = as_data_o;
        end else begin
          rx_q.push_back(as_data_o);  // Transfers on the next rising edge.
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
      err_count++;
    end
  endtask

  function automatic logic [39:0] read_cmd(input logic [15:0] addr);
    return {16'd0, addr, CMD_READ};
  endfunction

  function automatic logic [39:0] write_cmd(input logic [15:0] addr, input logic [15:0] data);
    return {data, addr, CMD_WRITE};
  endfunction

  // Register index in the reference model. Valid for mapped addresses only.
  function automatic int model_index(input logic [15:0] addr);
    wb_addr_u a;
    a.flat = addr;
    return int'(a.split.bank) * REGS_PER_BANK + int'(a.split.offset);
  endfunction

  task automatic add_test(input string name, input int ncmd, input logic [39:0] cmd,
                          input logic [7:0] code, input int nresp);
    t_name.push_back(name);
    t_ncmd.push_back(ncmd);
    t_cmd.push_back(cmd);
    t_code.push_back(code);
    t_nresp.push_back(nresp);
  endtask

  task automatic build_table();
    logic [15:0] d [NUM_BANKS];
    logic [15:0] addr;
    logic [15:0] data;
    for (int b = 0; b < NUM_BANKS; b++) begin
      d[b] = 16'($urandom);
    end
    add_test("ping", 1, {32'd0, CMD_PING}, RESP_PING, 1);
    add_test("nop", 1, {32'd0, CMD_NOP}, 8'd0, 0);
    add_test("ping_after_nop", 1, {32'd0, CMD_PING}, RESP_PING, 1);
    add_test("read_unwritten_b0", 3, read_cmd(16'h0003), RESP_ACK, 3);
    for (int b = 0; b < NUM_BANKS; b++) begin
      add_test($sformatf("write_bank%0d", b), 5, write_cmd({4'(b), 12'(b * 3 + 1)}, d[b]),
               RESP_ACK, 1);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      add_test($sformatf("read_bank%0d", b), 3, read_cmd({4'(b), 12'(b * 3 + 1)}),
               RESP_ACK, 3);
    end
    add_test("read_unwritten_b2_last", 3, read_cmd(16'h200f), RESP_ACK, 3);
    add_test("write_b1_r0", 5, write_cmd(16'h1000, 16'ha5c3), RESP_ACK, 1);
    // Bank 4 would alias onto bank 0 if only two bank bits were decoded.
    add_test("write_bad_bank", 5, write_cmd(16'h4001, 16'h1234), RESP_BUSERROR, 1);
    add_test("read_bad_bank", 3, read_cmd(16'h4001), RESP_BUSERROR, 1);
    add_test("write_bank_f", 5, write_cmd(16'hf001, 16'h5678), RESP_BUSERROR, 1);
    add_test("readback_after_bad_bank", 3, read_cmd(16'h0001), RESP_ACK, 3);
    add_test("write_bad_offset", 5, write_cmd(16'h1010, 16'h9abc), RESP_BUSERROR, 1);
    add_test("read_bad_offset", 3, read_cmd(16'h1ff0), RESP_BUSERROR, 1);
    add_test("readback_after_bad_offset", 3, read_cmd(16'h1000), RESP_ACK, 3);
    add_test("unknown_cmd_55", 1, {32'd0, 8'h55}, RESP_CMDERROR, 1);
    add_test("read_after_unknown", 3, read_cmd(16'h3007), RESP_ACK, 3);
    add_test("unknown_cmd_ff", 1, {32'd0, 8'hff}, RESP_CMDERROR, 1);
    add_test("ping_after_unknown", 1, {32'd0, CMD_PING}, RESP_PING, 1);
    for (int k = 0; k < 6; k++) begin
      addr = {4'($urandom % NUM_BANKS), 8'd0, 4'($urandom)};
      data = 16'($urandom);
      add_test($sformatf("rand_write_%0d", k), 5, write_cmd(addr, data), RESP_ACK, 1);
      add_test($sformatf("rand_read_%0d", k), 3, read_cmd(addr), RESP_ACK, 3);
    end
  endtask

  // Holds the strobe until the bridge is ready. The byte moves on the next rising edge.
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    as_data_i  = b;
    as_dstrb_i = 1'b1;
    while (as_busy_o) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_test(input int i);
    int          errs_before;
    int          rx_base;
    int          idx;
    int          busy_low;
    logic [39:0] cmd;
    logic [7:0]  exp_bytes [3];
    errs_before = err_count + hold_errors;
    rx_base     = rx_q.size();
    busy_low    = 0;
    cmd         = t_cmd[i];
    for (int k = 0; k < t_ncmd[i]; k++) begin
      send_byte(cmd[k*8 +: 8]);
    end
    @(negedge clk);
    as_dstrb_i = 1'b0;
    if (t_nresp[i] == 0) begin
      repeat (NOP_WAIT) @(negedge clk);
    end else begin
      while (rx_q.size() < rx_base + t_nresp[i]) begin
        if (as_busy_o !== 1'b1) begin
          busy_low++;  // Host must be held off until the last reply byte moves.
        end
        @(negedge clk);
      end
      while (as_busy_o || as_dstrb_o) begin
        @(negedge clk);
      end
    end

    exp_bytes[0] = t_code[i];
    exp_bytes[1] = 8'd0;
    exp_bytes[2] = 8'd0;
    if (t_nresp[i] == 3) begin
      idx          = model_index(cmd[23:8]);
      exp_bytes[1] = ref_regs[idx][7:0];   // Low byte first.
      exp_bytes[2] = ref_regs[idx][15:8];
    end
    check_value({t_name[i], " byte count"}, 32'(t_nresp[i]), 32'(rx_q.size() - rx_base));
    for (int k = 0; k < t_nresp[i] && rx_base + k < rx_q.size(); k++) begin
      check_value($sformatf("%s byte %0d", t_name[i], k), {24'd0, exp_bytes[k]},
                  {24'd0, rx_q[rx_base + k]});
    end
    if (t_nresp[i] != 0) begin
      check_value({t_name[i], " busy low cycles"}, 32'd0, 32'(busy_low));
    end

    if (cmd[7:0] == CMD_WRITE && t_code[i] == RESP_ACK) begin
      ref_regs[model_index(cmd[23:8])] = cmd[39:24];
    end
    if (err_count + hold_errors == errs_before) begin
      pass_count++;
      $display("Test %0d %s: ok", i, t_name[i]);
    end else begin
      $display("Test %0d %s: failed", i, t_name[i]);
    end
  endtask

  initial begin
    reset       = 1'b1;
    as_data_i   = 8'd0;
    as_dstrb_i  = 1'b0;
    err_count   = 0;
    check_count = 0;
    pass_count  = 0;
    seed_val    = $urandom(32'hf8f7);
    for (int r = 0; r < NUM_BANKS * REGS_PER_BANK; r++) begin
      ref_regs[r] = '0;  // Registers come out of reset as zero.
    end
    build_table();
    num_tests = t_name.size();

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    $display("Tests passed: %0d of %0d, checks: %0d, errors: %0d", pass_count, num_tests,
             check_count, err_count + hold_errors);
    if (err_count + hold_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    wait (num_tests > 0);
    repeat ((num_tests + 4) * CYCLES_PER_TEST) @(posedge clk);
    $display("Run timed out after %0d cycles, the DUT stopped responding",
             (num_tests + 4) * CYCLES_PER_TEST);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: files.f
hw/as_proto_pkg.sv
hw/wb_map_pkg.sv
hw/as_wb_bridge.sv
hw/wb_reg_bank.sv
hw/wb_resp_merge.sv
hw/as_wb_top.sv
tb/as_wb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass message.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module as_wb_tb -f files.f -o as_wb_sim

./obj_dir/as_wb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
